/* source/phy_pkg.sv */
package phy_pkg;

// ------------------------------
// GMII bus
// ------------------------------

localparam int gmii_width = 8;	// One byte per rxclk at gigabit rate

// ------------------------------
// Select synchronizer
// ------------------------------

localparam int sel_sync_stages = 2;	// Select comes from a switch or pin, not from rxclk

// ------------------------------
// Shared bus ownership
// ------------------------------

typedef enum logic
{
	arb_port0 = 1'b0,	// PHY0 drives the MAC receive bus and takes MAC transmit data
	arb_port1 = 1'b1	// Same for PHY1
} arb_state_t;

endpackage

/* source/phy_rx_port.sv */
`timescale 1ns/10ps

module phy_rx_port
	import phy_pkg::*;
(
	input	logic				rxclk,
	input	logic				rst,

	input	logic	[gmii_width-1:0]	rxdat,
	input	logic				rxdv,
	input	logic				rxer,
	input	logic				crs,
	input	logic				col,

	output	logic	[gmii_width-1:0]	port_rxdat,
	output	logic				port_rxdv,
	output	logic				port_rxer,
	output	logic				port_crs,
	output	logic				port_col,
	output	logic				frame_active
);

// ------------------------------
// Input register
// ------------------------------

always_ff @(posedge rxclk)
begin
	port_rxdat <= rxdat;
end

always_ff @(posedge rxclk)
begin
	if (rst)
	begin
		port_rxdv <= 1'b0;
		port_rxer <= 1'b0;
		port_crs <= 1'b0;
		port_col <= 1'b0;
	end
	else
	begin
		port_rxdv <= rxdv;
		port_rxer <= rxer;
		port_crs <= crs;
		port_col <= col;
	end
end

assign frame_active = port_rxdv;	// A frame lasts exactly as long as the registered rxdv

// The PHY must come out of reset without flagging a receive error
rxer_low_at_reset_release: assert property (@(posedge rxclk) $fell(rst) |-> !rxer)
	else $error("phy_rx_port: rxer high at reset release");

endmodule

/* source/phy_select_arbiter.sv */
`timescale 1ns/10ps

module phy_select_arbiter
	import phy_pkg::*;
(
	input	logic	rxclk,
	input	logic	rst,
	input	logic	select,
	input	logic	frame_active0,
	input	logic	frame_active1,
	input	logic	tx_busy,
	output	logic	grant
);

logic	[sel_sync_stages-1:0]	sel_meta;
logic				sel_sync;
logic				owner_active;
logic				switch_ok;
arb_state_t			state;

// ------------------------------
// Select synchronizer
// ------------------------------

always_ff @(posedge rxclk)
begin
	if (rst)
	begin
		sel_meta <= '0;
	end
	else
	begin
		sel_meta <= {sel_meta[sel_sync_stages-2:0], select};	// Shift in at the low end
	end
end

assign sel_sync = sel_meta[sel_sync_stages-1];

// ------------------------------
// Ownership FSM
// ------------------------------

assign owner_active = (state == arb_port1) ? frame_active1 : frame_active0;

// Hand over only in a gap on the owning port and with the MAC transmitter quiet
assign switch_ok = (sel_sync != grant) && !owner_active && !tx_busy;

always_ff @(posedge rxclk)
begin
	if (rst)
	begin
		state <= arb_port0;
	end
	else if (switch_ok)
	begin
		state <= (state == arb_port0) ? arb_port1 : arb_port0;
	end
end

assign grant = (state == arb_port1);

// A receive frame on the owning port is never cut by a handover
grant_held_in_rx_frame: assert property (@(posedge rxclk) disable iff (rst)
	owner_active |=> $stable(grant))
	else $error("phy_select_arbiter: grant moved during a receive frame");

// Same for a transmit frame coming from the MAC
grant_held_in_tx_frame: assert property (@(posedge rxclk) disable iff (rst)
	tx_busy |=> $stable(grant))
	else $error("phy_select_arbiter: grant moved during a transmit frame");

endmodule

/* source/phy_switch.sv */
`timescale 1ns/10ps

module phy_switch
	import phy_pkg::*;
(
	input	logic				rxclk,
	input	logic				rst,
	input	logic				grant,

	input	logic	[gmii_width-1:0]	port0_rxdat,
	input	logic				port0_rxdv,
	input	logic				port0_rxer,
	input	logic				port0_crs,
	input	logic				port0_col,

	input	logic	[gmii_width-1:0]	port1_rxdat,
	input	logic				port1_rxdv,
	input	logic				port1_rxer,
	input	logic				port1_crs,
	input	logic				port1_col,

	input	logic	[gmii_width-1:0]	txdat,
	input	logic				txen,
	input	logic				txer,

	output	logic	[gmii_width-1:0]	rxdat,
	output	logic				rxdv,
	output	logic				rxer,
	output	logic				crs,
	output	logic				col,

	output	logic	[gmii_width-1:0]	phy0_txdat,
	output	logic				phy0_txen,
	output	logic				phy0_txer,
	output	logic	[gmii_width-1:0]	phy1_txdat,
	output	logic				phy1_txen,
	output	logic				phy1_txer,
	output	logic				tx_busy
);

// ------------------------------
// Receive stage
// ------------------------------

always_ff @(posedge rxclk)
begin
	if (rst)
	begin
		rxdat <= '0;
		rxdv <= 1'b0;
		rxer <= 1'b0;
		crs <= 1'b0;
		col <= 1'b0;
	end
	else
	begin
		rxdat <= grant ? port1_rxdat : port0_rxdat;
		rxdv <= grant ? port1_rxdv : port0_rxdv;
		rxer <= grant ? port1_rxer : port0_rxer;
		crs <= grant ? port1_crs : port0_crs;
		col <= grant ? port1_col : port0_col;
	end
end

// ------------------------------
// Transmit stage
// ------------------------------

always_ff @(posedge rxclk)
begin
	if (rst || grant)
	begin
		phy0_txdat <= '0;	// Idle PHY sees a quiet bus
		phy0_txen <= 1'b0;
		phy0_txer <= 1'b0;
	end
	else
	begin
		phy0_txdat <= txdat;
		phy0_txen <= txen;
		phy0_txer <= txer;
	end
end

always_ff @(posedge rxclk)
begin
	if (rst || !grant)
	begin
		phy1_txdat <= '0;
		phy1_txen <= 1'b0;
		phy1_txer <= 1'b0;
	end
	else
	begin
		phy1_txdat <= txdat;
		phy1_txen <= txen;
		phy1_txer <= txer;
	end
end

// Covers the byte being captured this edge as well as the one already on the PHY
assign tx_busy = txen | phy0_txen | phy1_txen;

// Relies on the arbiter holding grant over a whole transmit frame
idle_phy_txen_low: assert property (@(posedge rxclk) disable iff (rst)
	grant ? !phy0_txen : !phy1_txen)
	else $error("phy_switch: txen high on the PHY that is not granted");

endmodule

/* source/phy_switch_top.sv */
`timescale 1ns/10ps

module phy_switch_top
	import phy_pkg::*;
(
	input	logic				rxclk,
	input	logic				rst,
	input	logic				select,

	input	logic	[gmii_width-1:0]	phy0_rxdat,
	input	logic				phy0_rxdv,
	input	logic				phy0_rxer,
	input	logic				phy0_crs,
	input	logic				phy0_col,
	output	logic	[gmii_width-1:0]	phy0_txdat,
	output	logic				phy0_txen,
	output	logic				phy0_txer,

	input	logic	[gmii_width-1:0]	phy1_rxdat,
	input	logic				phy1_rxdv,
	input	logic				phy1_rxer,
	input	logic				phy1_crs,
	input	logic				phy1_col,
	output	logic	[gmii_width-1:0]	phy1_txdat,
	output	logic				phy1_txen,
	output	logic				phy1_txer,

	output	logic	[gmii_width-1:0]	rxdat,
	output	logic				rxdv,
	output	logic				rxer,
	output	logic				crs,
	output	logic				col,
	input	logic	[gmii_width-1:0]	txdat,
	input	logic				txen,
	input	logic				txer
);

logic	[gmii_width-1:0]	port0_rxdat;
logic				port0_rxdv;
logic				port0_rxer;
logic				port0_crs;
logic				port0_col;
logic				frame_active0;

logic	[gmii_width-1:0]	port1_rxdat;
logic				port1_rxdv;
logic				port1_rxer;
logic				port1_crs;
logic				port1_col;
logic				frame_active1;

logic				grant;
logic				tx_busy;

// ------------------------------
// Receive ports
// ------------------------------

phy_rx_port rx_port0_i (
	.rxclk(rxclk), .rst(rst),
	.rxdat(phy0_rxdat), .rxdv(phy0_rxdv), .rxer(phy0_rxer), .crs(phy0_crs), .col(phy0_col),
	.port_rxdat(port0_rxdat), .port_rxdv(port0_rxdv), .port_rxer(port0_rxer),
	.port_crs(port0_crs), .port_col(port0_col), .frame_active(frame_active0)
);

phy_rx_port rx_port1_i (
	.rxclk(rxclk), .rst(rst),
	.rxdat(phy1_rxdat), .rxdv(phy1_rxdv), .rxer(phy1_rxer), .crs(phy1_crs), .col(phy1_col),
	.port_rxdat(port1_rxdat), .port_rxdv(port1_rxdv), .port_rxer(port1_rxer),
	.port_crs(port1_crs), .port_col(port1_col), .frame_active(frame_active1)
);

// ------------------------------
// Arbiter and steering
// ------------------------------

phy_select_arbiter arbiter_i (
	.rxclk(rxclk), .rst(rst), .select(select),
	.frame_active0(frame_active0), .frame_active1(frame_active1),
	.tx_busy(tx_busy), .grant(grant)
);

phy_switch switch_i (
	.rxclk(rxclk), .rst(rst), .grant(grant),
	.port0_rxdat(port0_rxdat), .port0_rxdv(port0_rxdv), .port0_rxer(port0_rxer),
	.port0_crs(port0_crs), .port0_col(port0_col),
	.port1_rxdat(port1_rxdat), .port1_rxdv(port1_rxdv), .port1_rxer(port1_rxer),
	.port1_crs(port1_crs), .port1_col(port1_col),
	.txdat(txdat), .txen(txen), .txer(txer),
	.rxdat(rxdat), .rxdv(rxdv), .rxer(rxer), .crs(crs), .col(col),
	.phy0_txdat(phy0_txdat), .phy0_txen(phy0_txen), .phy0_txer(phy0_txer),
	.phy1_txdat(phy1_txdat), .phy1_txen(phy1_txen), .phy1_txer(phy1_txer),
	.tx_busy(tx_busy)
);

endmodule

/* test/phy_switch_checker.sv */
`timescale 1ns/10ps

module phy_switch_checker
	import phy_pkg::*;
(
	input	logic				rxclk,
	input	logic				rst,
	input	logic				select,

	input	logic	[gmii_width-1:0]	phy0_rxdat,
	input	logic				phy0_rxdv,
	input	logic				phy0_rxer,
	input	logic				phy0_crs,
	input	logic				phy0_col,
	input	logic	[gmii_width-1:0]	phy0_txdat,
	input	logic				phy0_txen,
	input	logic				phy0_txer,

	input	logic	[gmii_width-1:0]	phy1_rxdat,
	input	logic				phy1_rxdv,
	input	logic				phy1_rxer,
	input	logic				phy1_crs,
	input	logic				phy1_col,
	input	logic	[gmii_width-1:0]	phy1_txdat,
	input	logic				phy1_txen,
	input	logic				phy1_txer,

	input	logic	[gmii_width-1:0]	rxdat,
	input	logic				rxdv,
	input	logic				rxer,
	input	logic				crs,
	input	logic				col,
	input	logic	[gmii_width-1:0]	txdat,
	input	logic				txen,
	input	logic				txer,

	output	int				error_count,
	output	int				check_count
);

logic	[gmii_width-1:0]	m_dat [2];	// Port registers, data is not reset
logic	[1:0]			m_dv;
logic	[1:0]			m_er;
logic	[1:0]			m_crs;
logic	[1:0]			m_col;
logic	[sel_sync_stages-1:0]	m_sel;
arb_state_t			m_state;
logic	[gmii_width-1:0]	m_rxdat;
logic				m_rxdv;
logic				m_rxer;
logic				m_crs_out;
logic				m_col_out;
logic	[gmii_width-1:0]	m_txdat [2];
logic	[1:0]			m_txen;
logic	[1:0]			m_txer;
logic				checking = 1'b0;
int				errors = 0;
int				checks = 0;

assign error_count = errors;
assign check_count = checks;

task automatic check_bus(input string name, input logic [gmii_width-1:0] actual,
	input logic [gmii_width-1:0] expected);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("ERROR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
	end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
	checks++;
	if (actual !== expected)
	begin
		errors++;
		$display("ERROR %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
	end
endtask

// ------------------------------
// Compare, then advance the model
// ------------------------------

always @(posedge rxclk)
begin : model
	logic gbit;
	logic busy;
	gbit = (m_state == arb_port1);
	busy = txen || m_txen[0] || m_txen[1];	// MAC still sending or a byte still on a PHY
	if (checking)
	begin
		check_bus("rxdat", rxdat, m_rxdat);
		check_bit("rxdv", rxdv, m_rxdv);
		check_bit("rxer", rxer, m_rxer);
		check_bit("crs", crs, m_crs_out);
		check_bit("col", col, m_col_out);
		check_bus("phy0_txdat", phy0_txdat, m_txdat[0]);
		check_bit("phy0_txen", phy0_txen, m_txen[0]);
		check_bit("phy0_txer", phy0_txer, m_txer[0]);
		check_bus("phy1_txdat", phy1_txdat, m_txdat[1]);
		check_bit("phy1_txen", phy1_txen, m_txen[1]);
		check_bit("phy1_txer", phy1_txer, m_txer[1]);
	end
	checking <= checking || rst;
	m_dat[0] <= phy0_rxdat;
	m_dat[1] <= phy1_rxdat;
	if (rst)
	begin
		m_dv <= '0;
		m_er <= '0;
		m_crs <= '0;
		m_col <= '0;
		m_sel <= '0;
		m_state <= arb_port0;
		m_rxdat <= '0;
		m_rxdv <= 1'b0;
		m_rxer <= 1'b0;
		m_crs_out <= 1'b0;
		m_col_out <= 1'b0;
		m_txdat[0] <= '0;
		m_txdat[1] <= '0;
		m_txen <= '0;
		m_txer <= '0;
	end
	else
	begin
		m_dv <= {phy1_rxdv, phy0_rxdv};
		m_er <= {phy1_rxer, phy0_rxer};
		m_crs <= {phy1_crs, phy0_crs};
		m_col <= {phy1_col, phy0_col};
		m_sel <= {m_sel[sel_sync_stages-2:0], select};
		if (m_sel[sel_sync_stages-1] != gbit && !m_dv[gbit] && !busy)
			m_state <= (m_state == arb_port0) ? arb_port1 : arb_port0;
		m_rxdat <= m_dat[gbit];
		m_rxdv <= m_dv[gbit];
		m_rxer <= m_er[gbit];
		m_crs_out <= m_crs[gbit];
		m_col_out <= m_col[gbit];
		m_txdat[gbit] <= txdat;
		m_txdat[!gbit] <= '0;
		m_txen <= gbit ? {txen, 1'b0} : {1'b0, txen};
		m_txer <= gbit ? {txer, 1'b0} : {1'b0, txer};
	end
end

endmodule

/* test/phy_switch_tb.sv */
`timescale 1ns/10ps

module phy_switch_tb
	import phy_pkg::*;
();

localparam int clk_period = 8;
localparam int reset_cycles = 5;
localparam int basic_cycles = 20;
localparam int forward_cycles = 200;
localparam int steer_cycles = 150;
localparam int wait_limit = 40;
localparam int soak_cycles = 2000;
localparam int timeout_cycles = reset_cycles + basic_cycles + 2 * forward_cycles
	+ 2 * steer_cycles + 2 * (10 + 20 + wait_limit) + soak_cycles + 100;

logic				rxclk = 1'b0;
logic				rst;
logic				select;
logic	[gmii_width-1:0]	phy_rxdat [2];
logic	[1:0]			phy_rxdv;
logic	[1:0]			phy_rxer;
logic	[1:0]			phy_crs;
logic	[1:0]			phy_col;
logic	[gmii_width-1:0]	phy0_txdat;
logic				phy0_txen;
logic				phy0_txer;
logic	[gmii_width-1:0]	phy1_txdat;
logic				phy1_txen;
logic				phy1_txer;
logic	[gmii_width-1:0]	rxdat;
logic				rxdv;
logic				rxer;
logic				crs;
logic				col;
logic	[gmii_width-1:0]	txdat;
logic				txen;
logic				txer;

integer	seed = 32'h54cccf28;
int	frame_left [2];
int	gap_left [2];
int	tx_left;
int	tx_gap;
int	check_errors;
int	check_total;
int	tb_errors = 0;
int	errors_at_start = 0;
int	tests_run = 0;
int	tests_passed = 0;
int	cycle;
int	frame_len;
int	delivered;
int	last_dv;
int	moved;
int	tx_count;
int	last_tx;
int	first_phy0;

always #(clk_period / 2) rxclk = ~rxclk;

phy_switch_top phy_switch_top_i (
	.rxclk(rxclk), .rst(rst), .select(select),
	.phy0_rxdat(phy_rxdat[0]), .phy0_rxdv(phy_rxdv[0]), .phy0_rxer(phy_rxer[0]),
	.phy0_crs(phy_crs[0]), .phy0_col(phy_col[0]),
	.phy0_txdat(phy0_txdat), .phy0_txen(phy0_txen), .phy0_txer(phy0_txer),
	.phy1_rxdat(phy_rxdat[1]), .phy1_rxdv(phy_rxdv[1]), .phy1_rxer(phy_rxer[1]),
	.phy1_crs(phy_crs[1]), .phy1_col(phy_col[1]),
	.phy1_txdat(phy1_txdat), .phy1_txen(phy1_txen), .phy1_txer(phy1_txer),
	.rxdat(rxdat), .rxdv(rxdv), .rxer(rxer), .crs(crs), .col(col),
	.txdat(txdat), .txen(txen), .txer(txer)
);

phy_switch_checker checker_i (
	.rxclk(rxclk), .rst(rst), .select(select),
	.phy0_rxdat(phy_rxdat[0]), .phy0_rxdv(phy_rxdv[0]), .phy0_rxer(phy_rxer[0]),
	.phy0_crs(phy_crs[0]), .phy0_col(phy_col[0]),
	.phy0_txdat(phy0_txdat), .phy0_txen(phy0_txen), .phy0_txer(phy0_txer),
	.phy1_rxdat(phy_rxdat[1]), .phy1_rxdv(phy_rxdv[1]), .phy1_rxer(phy_rxer[1]),
	.phy1_crs(phy_crs[1]), .phy1_col(phy_col[1]),
	.phy1_txdat(phy1_txdat), .phy1_txen(phy1_txen), .phy1_txer(phy1_txer),
	.rxdat(rxdat), .rxdv(rxdv), .rxer(rxer), .crs(crs), .col(col),
	.txdat(txdat), .txen(txen), .txer(txer),
	.error_count(check_errors), .check_count(check_total)
);

// ------------------------------
// Stimulus
// ------------------------------

// One byte time of a PHY, bursts of 4 to 20 bytes with short gaps
task automatic drive_phy(input bit k, input bit on);
	if (on && frame_left[k] == 0 && gap_left[k] == 0)
	begin
		frame_left[k] = 4 + $unsigned($random(seed)) % 17;
		gap_left[k] = 1 + $unsigned($random(seed)) % 8;
	end
	phy_rxdat[k] = 8'($random(seed));
	if (on && frame_left[k] != 0)
	begin
		phy_rxdv[k] = 1'b1;
		phy_rxer[k] = ($random(seed) & 31) == 0;
		phy_crs[k] = 1'b1;
		phy_col[k] = ($random(seed) & 63) == 0;
		frame_left[k]--;
	end
	else
	begin
		phy_rxdv[k] = 1'b0;
		phy_rxer[k] = 1'b0;
		phy_crs[k] = 1'b0;
		phy_col[k] = 1'b0;
		if (on && gap_left[k] != 0)
			gap_left[k]--;
	end
endtask

task automatic drive_cycle(input logic [1:0] rx_on, input logic tx_on);
	@(negedge rxclk);
	drive_phy(1'b0, rx_on[0]);
	drive_phy(1'b1, rx_on[1]);
	if (tx_on && tx_left == 0 && tx_gap == 0)
	begin
		tx_left = 4 + $unsigned($random(seed)) % 17;
		tx_gap = 1 + $unsigned($random(seed)) % 8;
	end
	txdat = 8'($random(seed));
	if (tx_on && tx_left != 0)
	begin
		txen = 1'b1;
		txer = ($random(seed) & 31) == 0;
		tx_left--;
	end
	else
	begin
		txen = 1'b0;
		txer = 1'b0;
		if (tx_on && tx_gap != 0)
			tx_gap--;
	end
endtask

task automatic start_test();
	errors_at_start = check_errors + tb_errors;
endtask

task automatic finish_test(input string name);
	int errs;
	errs = check_errors + tb_errors - errors_at_start;
	tests_run++;
	if (errs == 0)
	begin
		tests_passed++;
		$display("test %0d %s: ok", tests_run, name);
	end
	else
		$display("test %0d %s: %0d errors", tests_run, name, errs);
endtask

// ------------------------------
// Tests
// ------------------------------

initial
begin
	rst = 1'b1;
	select = 1'b0;
	phy_rxdat[0] = '0;
	phy_rxdat[1] = '0;
	phy_rxdv = '0;
	phy_rxer = '0;
	phy_crs = '0;
	phy_col = '0;
	txdat = '0;
	txen = 1'b0;
	txer = 1'b0;

	start_test();
	repeat (reset_cycles - 1) drive_cycle(2'b11, 1'b1);	// Traffic must not reach any output
	drive_cycle(2'b00, 1'b1);	// PHY receive lines idle at reset release
	rst = 1'b0;
	repeat (basic_cycles) drive_cycle(2'b00, 1'b1);
	finish_test("reset state");

	start_test();
	repeat (forward_cycles) drive_cycle(2'b11, 1'b0);
	select = 1'b1;
	repeat (forward_cycles) drive_cycle(2'b11, 1'b0);
	finish_test("receive forwarding");

	start_test();
	repeat (steer_cycles) drive_cycle(2'b00, 1'b1);
	select = 1'b0;
	repeat (steer_cycles) drive_cycle(2'b00, 1'b1);
	finish_test("transmit steering");

	// Select flips three bytes into a PHY0 frame
	start_test();
	repeat (10) drive_cycle(2'b00, 1'b0);
	frame_len = 12 + $unsigned($random(seed)) % 9;
	delivered = 0;
	last_dv = 0;
	moved = -1;
	for (cycle = 0; cycle < frame_len + wait_limit && moved < 0; cycle++)
	begin
		@(negedge rxclk);
		txdat = 8'h5a;	// Marks when PHY1 takes over
		txen = 1'b0;
		phy_rxdat[0] = 8'($random(seed));
		phy_rxdv[0] = cycle < frame_len;
		phy_crs[0] = cycle < frame_len;
		if (cycle == 3)
			select = 1'b1;
		if (rxdv)
		begin
			delivered++;
			last_dv = cycle;
		end
		if (phy1_txdat == 8'h5a)
			moved = cycle;
	end
	if (moved < 0)
	begin
		tb_errors++;
		$display("grant did not move to PHY1 within %0d cycles after the frame", wait_limit);
	end
	else
	begin
		if (delivered != frame_len)
		begin
			tb_errors++;
			$display("PHY0 frame was cut, %0d of %0d bytes delivered", delivered, frame_len);
		end
		if (moved <= last_dv || moved - 3 < 3)
		begin
			tb_errors++;
			$display("grant moved to PHY1 before the PHY0 frame had ended");
		end
	end
	finish_test("frame-safe switchover");

	// Select flips four bytes into a MAC transmit frame
	start_test();
	select = 1'b1;
	repeat (10) drive_cycle(2'b00, 1'b0);
	tx_count = 0;
	last_tx = 0;
	first_phy0 = -1;
	for (cycle = 0; cycle < 16 + wait_limit && first_phy0 < 0; cycle++)
	begin
		@(negedge rxclk);
		txen = cycle < 16;
		txdat = (cycle < 16) ? 8'($random(seed)) : 8'hc3;
		txer = 1'b0;
		if (cycle == 4)
			select = 1'b0;
		if (phy1_txen)
		begin
			tx_count++;
			last_tx = cycle;
		end
		if (phy0_txen || phy0_txdat != '0)
			first_phy0 = cycle;
	end
	if (first_phy0 < 0)
	begin
		tb_errors++;
		$display("PHY0 never took over the transmit path after select changed");
	end
	else if (tx_count != 16 || first_phy0 <= last_tx)
	begin
		tb_errors++;
		$display("transmit frame on PHY1 was split, %0d of 16 bytes sent", tx_count);
	end
	finish_test("transmit guard");

	start_test();
	for (cycle = 0; cycle < soak_cycles; cycle++)
	begin
		drive_cycle(2'b11, 1'b1);
		if (($random(seed) & 63) == 0)
			select = !select;
	end
	finish_test("random soak");

	$display("tests passed %0d of %0d, errors %0d, checks %0d", tests_passed, tests_run,
		check_errors + tb_errors, check_total);
	if (check_errors + tb_errors != 0 || tests_passed != tests_run)
		$display("*** TEST FAILED ***");
	else
		$display("*** TEST PASSED ***");
	$finish;
end

initial
begin
	#(timeout_cycles * clk_period);
	$display("TIMEOUT the run did not complete within %0d cycles", timeout_cycles);
	$display("*** TEST FAILED ***");
	$finish;
end

endmodule

/* sources.f */
source/phy_pkg.sv
source/phy_rx_port.sv
source/phy_select_arbiter.sv
source/phy_switch.sv
source/phy_switch_top.sv
test/phy_switch_checker.sv
test/phy_switch_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/10ps -j 0
TOP = phy_switch_tb
FILELIST = sources.f
BUILD_DIR = obj_dir
PASS_MSG = *** TEST PASSED ***

SIM = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
